// ==== src.f ====
+incdir+verilog
verilog/rvPkg.sv
verilog/ctrlIf.sv
verilog/rvController.sv
verilog/rvImmGen.sv
verilog/rvAlu.sv
verilog/rvRegFile.sv
verilog/rvLsu.sv
verilog/rvPcUnit.sv
verilog/rvCore.sv
verif/tbRvCore.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tbRvCore
FILELIST   := src.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing -sv
SIM_FLAGS  := --binary --timing -sv --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tbRvCore.sv ====
// Testbench for rvCore with memory models, instruction encoders and directed tests
`include "rv_defs.svh"

module tbRvCore;

    logic        clk;
    logic        rstN;
    logic [31:0] imemData;
    logic [31:0] dmemRdata;
    logic [31:0] imemAddr;
    logic [31:0] dmemAddr;
    logic [31:0] dmemWdata;
    logic [3:0]  dmemStrb;
    logic        dmemWen;
    logic        dmemRen;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:511];
    logic [31:0] seed;
    int          progLen;
    logic [31:0] resAddr;   // Next result slot
    logic        pendWen;   // Store sampled at negedge and committed at posedge
    logic [31:0] pendAddr;
    logic [31:0] pendData;
    logic [3:0]  pendStrb;

    logic [31:0] expAddr[$], expData[$], expTrace[$];
    logic [3:0]  expStrb[$];
    logic        expRen[$];
    logic [31:0] capAddr[$], capData[$], capTrace[$];
    logic [3:0]  capStrb[$];
    logic        capRen[$];

    rvCore rvCore_i (
        .clk(clk), .rstN(rstN), .imemData(imemData), .dmemRdata(dmemRdata),
        .imemAddr(imemAddr), .dmemAddr(dmemAddr), .dmemWdata(dmemWdata),
        .dmemStrb(dmemStrb), .dmemWen(dmemWen), .dmemRen(dmemRen)
    );

    // Combinational memory reads
    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRdata = dmem[dmemAddr[10:2]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (pendWen) begin
            for (int b = 0; b < 4; b++) begin
                if (pendStrb[b]) dmem[pendAddr[10:2]][8*b +: 8] = pendData[8*b +: 8];
            end
            pendWen = 1'b0;
        end
    end

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] fillWord(input int idx);
        return (32'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    // Reference ALU from the ISA definitions
    function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a + ~b + 32'd1 : a + b;
            3'd1: return a << sh;
            3'd2: return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return (alt && a[31]) ? (a >> sh) | ~(32'hFFFF_FFFF >> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        logic sLess;
        sLess = (a[31] != b[31]) ? a[31] : (a < b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return sLess;
            3'd5: return !sLess;
            3'd6: return a < b;
            default: return !(a < b);
        endcase
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] old, input logic [31:0] data,
                                               input logic [3:0] strb);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    task automatic checkVal(input string test, input string what, input logic [31:0] exp,
                            input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch %s %s expected %h actual %h", test, what, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic startProg();
        progLen = 0;
        resAddr = 32'h400;
        expAddr.delete();
        expData.delete();
        expStrb.delete();
        expTrace.delete();
        expRen.delete();
        for (int i = 0; i < 256; i++) imem[i] = encJ(21'd0, 5'd0);  // Self loops
        for (int i = 0; i < 512; i++) dmem[i] = fillWord(i);
    endtask

    task automatic emit(input logic [31:0] inst);
        imem[progLen] = inst;
        expTrace.push_back(32'(progLen * 4));
        expRen.push_back(inst[6:0] == `RV_OP_LOAD);  // Only loads read data memory
        progLen++;
    endtask

    // Placed at a target that control flow jumps over
    task automatic emitSkipped(input logic [31:0] inst);
        imem[progLen] = inst;
        progLen++;
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        expAddr.push_back(addr);
        expData.push_back(data);
        expStrb.push_back(strb);
    endtask

    task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] up;
        up = v + 32'h800;  // Compensates the sign of the low part
        emit(encU(up[31:12], rd, `RV_OP_LUI));
        emit(encI(v[11:0], rd, 3'd0, rd, `RV_OP_IMM));
    endtask

    task automatic storeResult(input logic [4:0] rs, input logic [31:0] expected);
        emit(encS(resAddr[11:0], rs, 5'd0, 3'd2));
        expectStore(resAddr, expected, 4'hF);
        resAddr += 32'd4;
    endtask

    task automatic runProg(input string test);
        int  cyc;
        logic done;
        emit(encS(12'h7FC, 5'd0, 5'd0, 3'd2));  // End marker
        expectStore(32'h7FC, 32'd0, 4'hF);
        capAddr.delete();
        capData.delete();
        capStrb.delete();
        capTrace.delete();
        capRen.delete();
        @(posedge clk);
        #1 rstN = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            assert (dmemWen === 1'b0) else begin
                $display("Data write enable was high during reset in %s", test);
                $display("TESTS FAILED");
                $fatal(1);
            end
            checkVal(test, "reset pc", `RV_RESET_PC, imemAddr);
        end
        @(posedge clk);
        #1 rstN = 1'b1;
        done = 1'b0;
        cyc = 0;
        while (!done && cyc < 1000) begin
            @(negedge clk);
            capTrace.push_back(imemAddr);
            capRen.push_back(dmemRen);
            if (dmemWen) begin
                capAddr.push_back(dmemAddr);
                capData.push_back(dmemWdata);
                capStrb.push_back(dmemStrb);
                pendAddr = dmemAddr;
                pendData = dmemWdata;
                pendStrb = dmemStrb;
                pendWen  = 1'b1;
                done = (dmemAddr == 32'h7FC);
            end
            cyc++;
        end
        assert (done) else begin
            $display("Program in %s never reached its final store", test);
            $display("TESTS FAILED");
            $fatal(1);
        end
        checkVal(test, "store count", 32'(expAddr.size()), 32'(capAddr.size()));
        for (int i = 0; i < expAddr.size(); i++) begin
            checkVal(test, $sformatf("store %0d addr", i), expAddr[i], capAddr[i]);
            checkVal(test, $sformatf("store %0d data", i), expData[i], capData[i]);
            checkVal(test, $sformatf("store %0d strb", i), {28'b0, expStrb[i]},
                     {28'b0, capStrb[i]});
        end
        checkVal(test, "trace length", 32'(expTrace.size()), 32'(capTrace.size()));
        for (int i = 0; i < expTrace.size(); i++) begin
            checkVal(test, $sformatf("fetch %0d", i), expTrace[i], capTrace[i]);
            checkVal(test, $sformatf("fetch %0d read enable", i), {31'b0, expRen[i]},
                     {31'b0, capRen[i]});
        end
    endtask

    task automatic aluTest();
        logic [31:0] a, b, r;
        logic [11:0] imm;
        logic        alt;
        startProg();
        for (int it = 0; it < 3; it++) begin
            a = nextRand();
            b = nextRand();
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            for (int f = 0; f < 8; f++) begin
                for (int s = 0; s < 2; s++) begin
                    alt = s[0];
                    if (!alt || f == 0 || f == 5) begin
                        emit(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f), 5'd3, `RV_OP_REG));
                        storeResult(5'd3, refAlu(3'(f), alt, a, b));
                    end
                end
            end
            for (int f = 0; f < 8; f++) begin
                r = nextRand();
                if (f == 1 || f == 5) begin
                    for (int s = 0; s < 2; s++) begin
                        alt = s[0];
                        if (!alt || f == 5) begin
                            imm = {alt ? 7'h20 : 7'h00, r[4:0]};
                            emit(encI(imm, 5'd1, 3'(f), 5'd3, `RV_OP_IMM));
                            storeResult(5'd3, refAlu(3'(f), alt, a, {27'b0, r[4:0]}));
                        end
                    end
                end else begin
                    imm = r[11:0];
                    emit(encI(imm, 5'd1, 3'(f), 5'd3, `RV_OP_IMM));
                    storeResult(5'd3, refAlu(3'(f), 1'b0, a, {{20{imm[11]}}, imm}));
                end
            end
        end
        runProg("aluTest");
    endtask

    task automatic loadTest();
        logic [31:0] w;
        logic [7:0]  by;
        logic [15:0] hw;
        startProg();
        dmem[64] = nextRand() & 32'h7F7F_7F7F;  // Positive lanes
        dmem[65] = nextRand() | 32'h8080_8080;  // Negative lanes
        emit(encI(12'h100, 5'd0, 3'd0, 5'd1, `RV_OP_IMM));
        for (int wi = 0; wi < 2; wi++) begin
            w = dmem[64 + wi];
            for (int off = 0; off < 4; off++) begin
                by = w[8*off +: 8];
                emit(encI(12'(4*wi + off), 5'd1, 3'd0, 5'd3, `RV_OP_LOAD));
                storeResult(5'd3, {{24{by[7]}}, by});
                emit(encI(12'(4*wi + off), 5'd1, 3'd4, 5'd3, `RV_OP_LOAD));
                storeResult(5'd3, {24'b0, by});
            end
            for (int off = 0; off < 4; off += 2) begin
                hw = w[8*off +: 16];
                emit(encI(12'(4*wi + off), 5'd1, 3'd1, 5'd3, `RV_OP_LOAD));
                storeResult(5'd3, {{16{hw[15]}}, hw});
                emit(encI(12'(4*wi + off), 5'd1, 3'd5, 5'd3, `RV_OP_LOAD));
                storeResult(5'd3, {16'b0, hw});
            end
            emit(encI(12'(4*wi), 5'd1, 3'd2, 5'd3, `RV_OP_LOAD));
            storeResult(5'd3, w);
        end
        runProg("loadTest");
    endtask

    task automatic storeTest();
        logic [31:0] d;
        logic [31:0] words [0:6];
        logic [3:0]  strb;
        startProg();
        d = nextRand();
        for (int i = 0; i < 7; i++) words[i] = fillWord(96 + i);  // Words from 0x180
        loadConst(5'd2, d);
        emit(encI(12'h180, 5'd0, 3'd0, 5'd1, `RV_OP_IMM));
        for (int k = 0; k < 4; k++) begin
            strb = 4'b0001 << k;
            emit(encS(12'(5*k), 5'd2, 5'd1, 3'd0));
            expectStore(32'h180 + 32'(5*k), {4{d[7:0]}}, strb);
            words[k] = mergeBytes(words[k], {4{d[7:0]}}, strb);
        end
        for (int k = 0; k < 2; k++) begin
            strb = (k == 1) ? 4'b1100 : 4'b0011;
            emit(encS(12'(16 + 6*k), 5'd2, 5'd1, 3'd1));
            expectStore(32'h190 + 32'(6*k), {2{d[15:0]}}, strb);
            words[4 + k] = mergeBytes(words[4 + k], {2{d[15:0]}}, strb);
        end
        emit(encS(12'd24, 5'd2, 5'd1, 3'd2));
        expectStore(32'h198, d, 4'hF);
        words[6] = d;
        // Read back every touched word
        for (int i = 0; i < 7; i++) begin
            emit(encI(12'(4*i), 5'd1, 3'd2, 5'd3, `RV_OP_LOAD));
            storeResult(5'd3, words[i]);
        end
        runProg("storeTest");
    endtask

    task automatic controlTest();
        logic [31:0] opA [0:2];
        logic [31:0] opB [0:2];
        logic [2:0]  f3s [0:5];
        logic        taken;
        logic [31:0] link;
        int          p;
        startProg();
        opA[0] = nextRand();
        opB[0] = opA[0];
        opA[1] = 32'hFFFF_FFF0;
        opB[1] = 32'h10;
        opA[2] = 32'h10;
        opB[2] = 32'hFFFF_FFF0;
        f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        for (int pi = 0; pi < 3; pi++) begin
            loadConst(5'd1, opA[pi]);
            loadConst(5'd2, opB[pi]);
            for (int bi = 0; bi < 6; bi++) begin
                taken = branchTaken(f3s[bi], opA[pi], opB[pi]);
                emit(encI(12'd0, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
                emit(encB(13'd8, 5'd2, 5'd1, f3s[bi]));
                if (taken) emitSkipped(encI(12'd1, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
                else emit(encI(12'd1, 5'd0, 3'd0, 5'd3, `RV_OP_IMM));
                storeResult(5'd3, taken ? 32'd0 : 32'd1);
            end
        end
        link = 32'(progLen * 4) + 32'd4;
        emit(encJ(21'd8, 5'd4));
        emitSkipped(encS(12'h7F0, 5'd0, 5'd0, 3'd2));  // Stray store if jump fails
        storeResult(5'd4, link);
        // JALR with an odd offset whose bit 0 is dropped from the target
        p = progLen;
        emit(encI(12'((p + 3) * 4), 5'd0, 3'd0, 5'd6, `RV_OP_IMM));
        emit(encI(12'd1, 5'd6, 3'd0, 5'd7, `RV_OP_JALR));
        emitSkipped(encS(12'h7F0, 5'd0, 5'd0, 3'd2));
        storeResult(5'd7, 32'((p + 2) * 4));
        runProg("controlTest");
    endtask

    task automatic upperTest();
        logic [31:0] r;
        logic [31:0] pcv;
        startProg();
        storeResult(5'd0, 32'd0);  // A store sits at the reset PC while reset is held
        r = nextRand();
        emit(encU(r[31:12], 5'd3, `RV_OP_LUI));
        storeResult(5'd3, {r[31:12], 12'b0});
        r = nextRand();
        pcv = 32'(progLen * 4);
        emit(encU(r[31:12], 5'd3, `RV_OP_AUIPC));
        storeResult(5'd3, pcv + {r[31:12], 12'b0});
        loadConst(5'd1, nextRand() | 32'h1);
        emit(encI(12'h055, 5'd0, 3'd0, 5'd0, `RV_OP_IMM));
        emit(encR(7'h00, 5'd1, 5'd1, 3'd0, 5'd0, `RV_OP_REG));
        storeResult(5'd0, 32'd0);
        runProg("upperTest");
    endtask

    initial begin
        rstN    = 1'b0;
        seed    = 32'd33639;
        pendWen = 1'b0;
        startProg();
        aluTest();
        loadTest();
        storeTest();
        controlTest();
        upperTest();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog/rvCore.sv ====
// Single-cycle RV32I core top level with plain instruction and data ports
`include "rv_defs.svh"

module rvCore (
    input  logic        clk,
    input  logic        rstN,
    input  rvPkg::instT imemData,
    input  rvPkg::wordT dmemRdata,
    output rvPkg::wordT imemAddr,
    output rvPkg::wordT dmemAddr,
    output rvPkg::wordT dmemWdata,
    output rvPkg::strbT dmemStrb,
    output logic        dmemWen,
    output logic        dmemRen
);

    rvPkg::regAddrT rs1;
    rvPkg::regAddrT rs2;
    rvPkg::regAddrT rd;
    rvPkg::wordT    imm;
    rvPkg::wordT    rs1Data;
    rvPkg::wordT    rs2Data;
    rvPkg::wordT    aluOpB;
    rvPkg::wordT    aluResult;
    rvPkg::wordT    loadData;
    rvPkg::wordT    pc;
    rvPkg::wordT    pcPlus4;
    rvPkg::wordT    wbData;
    logic           regWen;

    ctrlIf ctrlBus ();

    assign rs1 = imemData[19:15];
    assign rs2 = imemData[24:20];
    assign rd  = imemData[11:7];

    rvController rvController_i (.inst(imemData), .ctrl(ctrlBus.ctrl));

    rvImmGen rvImmGen_i (.inst(imemData), .imm(imm));

    rvRegFile rvRegFile_i (
        .clk(clk), .rstN(rstN),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .wen(regWen), .wdata(wbData),
        .rdata1(rs1Data), .rdata2(rs2Data)
    );

    assign aluOpB = ctrlBus.aluSrc ? imm : rs2Data;

    rvAlu rvAlu_i (.opA(rs1Data), .opB(aluOpB), .aluCtrl(ctrlBus.aluCtrl), .result(aluResult));

    rvLsu rvLsu_i (
        .ctrl(ctrlBus.dp), .addr(aluResult), .storeData(rs2Data), .memRdata(dmemRdata),
        .memWdata(dmemWdata), .memStrb(dmemStrb), .loadData(loadData)
    );

    rvPcUnit rvPcUnit_i (
        .clk(clk), .rstN(rstN), .ctrl(ctrlBus.dp), .func3(imemData[14:12]),
        .rs1Data(rs1Data), .rs2Data(rs2Data), .imm(imm),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    always_comb begin
        case (ctrlBus.wbSel)
            `RV_WB_MEM:   wbData = loadData;
            `RV_WB_PC4:   wbData = pcPlus4;   // Link value
            `RV_WB_PCIMM: wbData = pc + imm;  // AUIPC
            default:      wbData = aluResult;
        endcase
    end

    // Memory returns a real instruction during reset so side effects are held off
    assign regWen  = ctrlBus.regWrite & rstN;
    assign dmemWen = ctrlBus.memWrite & rstN;
    assign dmemRen = ctrlBus.memRead & rstN;

    assign imemAddr = pc;
    assign dmemAddr = aluResult;

endmodule

// ==== verilog/rvPcUnit.sv ====
// PC register, branch compare and next-PC select
`include "rv_defs.svh"

module rvPcUnit (
    input  logic        clk,
    input  logic        rstN,
    ctrlIf.dp           ctrl,
    input  logic [2:0]  func3,
    input  rvPkg::wordT rs1Data,
    input  rvPkg::wordT rs2Data,
    input  rvPkg::wordT imm,
    output rvPkg::wordT pc,
    output rvPkg::wordT pcPlus4
);

    logic        condMet;
    logic        takeRel;     // Jump relative to pc
    rvPkg::wordT jalrTarget;
    rvPkg::wordT nextPc;

    always_comb begin
        case (func3)
            3'b000:  condMet = rs1Data == rs2Data;                    // BEQ
            3'b001:  condMet = rs1Data != rs2Data;                    // BNE
            3'b100:  condMet = $signed(rs1Data) < $signed(rs2Data);   // BLT
            3'b101:  condMet = $signed(rs1Data) >= $signed(rs2Data);  // BGE
            3'b110:  condMet = rs1Data < rs2Data;
            3'b111:  condMet = rs1Data >= rs2Data;
            default: condMet = 1'b0;
        endcase
    end

    assign takeRel    = ctrl.jal || (ctrl.branch && condMet);
    assign jalrTarget = rs1Data + imm;
    assign pcPlus4    = pc + 32'd4;

    assign nextPc = ctrl.jalr ? {jalrTarget[31:1], 1'b0} :
                    takeRel   ? pc + imm : pcPlus4;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// ==== verilog/rvLsu.sv ====
// Load and store alignment, byte strobes and load extension
`include "rv_defs.svh"

module rvLsu (
    ctrlIf.dp           ctrl,
    input  rvPkg::wordT addr,
    input  rvPkg::wordT storeData,
    input  rvPkg::wordT memRdata,
    output rvPkg::wordT memWdata,
    output rvPkg::strbT memStrb,
    output rvPkg::wordT loadData
);

    logic [1:0]  offset;
    rvPkg::strbT laneStrb;
    rvPkg::wordT lane;     // Selected bytes moved down to bit 0

    assign offset = addr[1:0];

    // Small stores are replicated so every lane sees the data
    always_comb begin
        case (ctrl.dataLen)
            `RV_LEN_BYTE: begin
                memWdata = {4{storeData[7:0]}};
                laneStrb = rvPkg::strbT'(4'b0001 << offset);
            end
            `RV_LEN_HALF: begin
                memWdata = {2{storeData[15:0]}};
                laneStrb = offset[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                memWdata = storeData;
                laneStrb = 4'b1111;
            end
        endcase
    end

    assign memStrb = ctrl.memWrite ? laneStrb : '0;

    assign lane = memRdata >> {offset, 3'b000};

    always_comb begin
        case (ctrl.dataLen)
            `RV_LEN_BYTE: loadData = {{24{ctrl.dataSign & lane[7]}}, lane[7:0]};
            `RV_LEN_HALF: loadData = {{16{ctrl.dataSign & lane[15]}}, lane[15:0]};
            default:      loadData = memRdata;
        endcase
    end

endmodule

// ==== verilog/rvRegFile.sv ====
// Integer register file with x0 tied to zero, two read ports and one write port
`include "rv_defs.svh"

module rvRegFile (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::regAddrT rs1,
    input  rvPkg::regAddrT rs2,
    input  rvPkg::regAddrT rd,
    input  logic           wen,
    input  rvPkg::wordT    wdata,
    output rvPkg::wordT    rdata1,
    output rvPkg::wordT    rdata2
);

    // No storage behind x0
    rvPkg::wordT regs [1:`RV_NUM_REGS-1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== verilog/rvAlu.sv ====
// Arithmetic, logic, shift, compare and pass-through unit
`include "rv_defs.svh"

module rvAlu (
    input  rvPkg::wordT    opA,
    input  rvPkg::wordT    opB,
    input  rvPkg::aluCtrlT aluCtrl,
    output rvPkg::wordT    result
);

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = opB[4:0];
    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb begin
        case (aluCtrl)
            `RV_ALU_ADD:  result = opA + opB;
            `RV_ALU_SUB:  result = opA - opB;
            `RV_ALU_SLL:  result = opA << shamt;
            `RV_ALU_SLT:  result = {31'b0, ltSigned};
            `RV_ALU_SLTU: result = {31'b0, ltUnsigned};
            `RV_ALU_XOR:  result = opA ^ opB;
            `RV_ALU_SRL:  result = opA >> shamt;
            `RV_ALU_SRA:  result = $signed(opA) >>> shamt;  // Keeps sign bit
            `RV_ALU_OR:   result = opA | opB;
            `RV_ALU_AND:  result = opA & opB;
            `RV_ALU_PASS: result = opB;
            default:      result = '0;
        endcase
    end

endmodule

// ==== verilog/rvImmGen.sv ====
// Immediate generator for I, S, B, U and J formats
`include "rv_defs.svh"

module rvImmGen (
    input  rvPkg::instT inst,
    output rvPkg::wordT imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (inst[6:0])
            `RV_OP_IMM, `RV_OP_LOAD, `RV_OP_JALR:
                imm = {{21{sign}}, inst[30:20]};
            `RV_OP_STORE:
                imm = {{21{sign}}, inst[30:25], inst[11:7]};
            `RV_OP_BRANCH:   // Offset in multiples of two
                imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            `RV_OP_LUI, `RV_OP_AUIPC:
                imm = {inst[31:12], 12'b0};  // Field goes to upper bits
            `RV_OP_JAL:
                imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

// ==== verilog/rvController.sv ====
// Instruction decoder producing the control bundle from opcode, func3 and func7
`include "rv_defs.svh"

module rvController (
    input rvPkg::instT inst,
    ctrlIf.ctrl        ctrl
);

    logic [6:0] opcode;
    logic [2:0] func3;
    logic       altOp;    // func7 bit 5 selecting SUB and SRA

    assign opcode = inst[6:0];
    assign func3  = inst[14:12];
    assign altOp  = inst[30];

    function automatic rvPkg::aluCtrlT aluFromFunc(input logic [2:0] f3, input logic alt);
        rvPkg::aluCtrlT code;
        case (f3)
            3'b000:  code = alt ? `RV_ALU_SUB : `RV_ALU_ADD;
            3'b001:  code = `RV_ALU_SLL;
            3'b010:  code = `RV_ALU_SLT;
            3'b011:  code = `RV_ALU_SLTU;
            3'b100:  code = `RV_ALU_XOR;
            3'b101:  code = alt ? `RV_ALU_SRA : `RV_ALU_SRL;
            3'b110:  code = `RV_ALU_OR;
            default: code = `RV_ALU_AND;
        endcase
        return code;
    endfunction

    always_comb begin
        ctrl.wbSel    = `RV_WB_ALU;
        ctrl.memWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.jal      = 1'b0;
        ctrl.jalr     = 1'b0;
        ctrl.aluCtrl  = `RV_ALU_ADD;  // Address adds for loads and stores
        ctrl.aluSrc   = 1'b0;
        ctrl.regWrite = 1'b0;
        case (opcode)
            `RV_OP_LOAD: begin
                ctrl.wbSel    = `RV_WB_MEM;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `RV_OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            `RV_OP_BRANCH: begin
                ctrl.branch  = 1'b1;
                ctrl.aluCtrl = `RV_ALU_SUB;
            end
            `RV_OP_JAL: begin
                ctrl.jal      = 1'b1;
                ctrl.wbSel    = `RV_WB_PC4;
                ctrl.regWrite = 1'b1;
            end
            `RV_OP_JALR: begin
                ctrl.jalr     = 1'b1;
                ctrl.wbSel    = `RV_WB_PC4;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `RV_OP_IMM: begin
                // Bit 30 is part of the immediate except on right shifts
                ctrl.aluCtrl  = aluFromFunc(func3, altOp && (func3 == 3'b101));
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `RV_OP_REG: begin
                ctrl.aluCtrl  = aluFromFunc(func3, altOp);
                ctrl.regWrite = 1'b1;
            end
            `RV_OP_LUI: begin
                ctrl.aluCtrl  = `RV_ALU_PASS;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            `RV_OP_AUIPC: begin
                ctrl.wbSel    = `RV_WB_PCIMM;
                ctrl.regWrite = 1'b1;
            end
            default: ;  // Unsupported opcodes retire as no-ops
        endcase
    end

    // Size from func3 low bits since LBU and LHU only add bit 2
    always_comb begin
        case (func3[1:0])
            2'b00:   ctrl.dataLen = `RV_LEN_BYTE;
            2'b01:   ctrl.dataLen = `RV_LEN_HALF;
            default: ctrl.dataLen = `RV_LEN_WORD;
        endcase
    end

    assign ctrl.dataSign = ~func3[2];

endmodule

// ==== verilog/ctrlIf.sv ====
// Decoded control signal bundle between controller and datapath
interface ctrlIf;

    rvPkg::wbSelT   wbSel;    // Writeback source
    logic           memWrite;
    logic           memRead;
    logic           branch;   // Conditional branch
    logic           jal;
    logic           jalr;
    rvPkg::aluCtrlT aluCtrl;
    logic           aluSrc;   // 1 picks immediate for operand 2
    logic           regWrite;
    rvPkg::dataLenT dataLen;
    logic           dataSign; // Sign extend loads

    modport ctrl (
        output wbSel, memWrite, memRead, branch, jal, jalr,
        output aluCtrl, aluSrc, regWrite, dataLen, dataSign
    );

    modport dp (
        input wbSel, memWrite, memRead, branch, jal, jalr,
        input aluCtrl, aluSrc, regWrite, dataLen, dataSign
    );

endinterface

// ==== verilog/rvPkg.sv ====
// Vector types shared by the core datapath and controller
package rvPkg;

    // Data or address word
    typedef logic [31:0] wordT;

    // Raw instruction word from the fetch port
    typedef logic [31:0] instT;

    // Register index
    typedef logic [4:0] regAddrT;

    // ALU operation code
    typedef logic [3:0] aluCtrlT;

    // Writeback source select
    //   0 ALU result
    //   1 load data
    //   2 PC+4 for links
    //   3 PC+imm for AUIPC
    typedef logic [1:0] wbSelT;

    // Access size with byte 0, half 1 and word 3
    typedef logic [1:0] dataLenT;

    // Byte write strobes where bit n covers bits 8n+7..8n
    typedef logic [3:0] strbT;

endpackage

// ==== verilog/rv_defs.svh ====
// Reset PC, register count, opcode, writeback, access size and ALU operation macros
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_RESET_PC   32'h0000_0000
`define RV_NUM_REGS   32

// Major opcodes
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111

// Writeback sources
`define RV_WB_ALU     2'd0
`define RV_WB_MEM     2'd1
`define RV_WB_PC4     2'd2
`define RV_WB_PCIMM   2'd3

// Access size codes with word as 3
`define RV_LEN_BYTE   2'd0
`define RV_LEN_HALF   2'd1
`define RV_LEN_WORD   2'd3

`define RV_ALU_ADD    4'd0
`define RV_ALU_SUB    4'd1
`define RV_ALU_SLL    4'd2
`define RV_ALU_SLT    4'd3
`define RV_ALU_SLTU   4'd4
`define RV_ALU_XOR    4'd5
`define RV_ALU_SRL    4'd6
`define RV_ALU_SRA    4'd7
`define RV_ALU_OR     4'd8
`define RV_ALU_AND    4'd9
`define RV_ALU_PASS   4'd10 // Forwards operand 2 for LUI

`endif
